/* logic/edge_pe_config.svh */
`ifndef EDGE_PE_CONFIG_SVH
`define EDGE_PE_CONFIG_SVH

// node ids
`define NODE_ID_WIDTH 7

// feature beats split into bank lanes
`define FV_WIDTH      16
`define FV_LANES      4
`define FV_BEAT_WIDTH 64

// neighbor list beats
`define ID_BEAT_WIDTH 64

// id k sits at bits 7k+6:7k with bit 63 spare
`define IDS_PER_BEAT  9

// three list beats worth
`define MAX_NEIGHBORS 27

`endif

/* logic/edge_pe_ctrl.sv */
`default_nettype none

module edge_pe_ctrl (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             task_valid,
    input  wire edge_pe_pkg::node_id_t      task_node,
    input  wire                             grant,
    input  wire                             list_ready,
    input  wire edge_pe_pkg::neighbor_cnt_t neighbor_count,
    input  wire edge_pe_pkg::node_id_t      read_node,
    input  wire                             stream_done,
    output logic                            idle,
    output logic                            bus_req,
    output edge_pe_pkg::req_type_t          bus_req_type,
    output edge_pe_pkg::node_id_t           bus_node_id,
    output logic                            capture_en,
    output logic                            forward_en,
    output edge_pe_pkg::neighbor_cnt_t      read_index,
    output edge_pe_pkg::node_id_t           target_node,
    output logic                            done_aggr
);
    import edge_pe_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ_LIST,
        S_WAIT_LIST,
        S_REQ_FV,
        S_WAIT_FV,
        S_COMPLETE
    } state_t;

    state_t        state;
    state_t        nx_state;
    neighbor_cnt_t fv_ptr;
    logic          last_neighbor;

    // pointer still names the neighbor whose stream just ended
    assign last_neighbor = (fv_ptr + neighbor_cnt_t'(1)) == neighbor_count;

    always_comb begin
        nx_state = state;
        case (state)
            S_IDLE:
                if (task_valid)
                    nx_state = S_REQ_LIST;
            S_REQ_LIST:
                if (grant)
                    nx_state = S_WAIT_LIST;
            S_WAIT_LIST:
                if (list_ready)
                    nx_state = S_REQ_FV;
            S_REQ_FV:
                if (grant)
                    nx_state = S_WAIT_FV;
            S_WAIT_FV:
                if (stream_done)
                    nx_state = last_neighbor ? S_COMPLETE : S_REQ_FV;
            S_COMPLETE:
                nx_state = S_IDLE;
            default:
                nx_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            fv_ptr <= '0;
        end else begin
            state <= nx_state;
            if (state == S_IDLE)
                fv_ptr <= '0;
            else if (state == S_WAIT_FV && stream_done)
                fv_ptr <= fv_ptr + neighbor_cnt_t'(1);  // next neighbor in list order
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && task_valid)
            target_node <= task_node;
    end

    assign idle       = (state == S_IDLE);
    assign bus_req    = (state == S_REQ_LIST) || (state == S_REQ_FV);
    assign capture_en = (state == S_WAIT_LIST);
    assign forward_en = (state == S_WAIT_FV);
    assign done_aggr  = (state == S_COMPLETE);
    assign read_index = fv_ptr;

    // list request addresses the target, feature request the neighbor
    assign bus_req_type = (state == S_REQ_FV) ? REQ_NEIGHBOR_FV : REQ_NEIGHBOR_ID;
    assign bus_node_id  = (state == S_REQ_FV) ? read_node : target_node;

    // a late grant holds the request unchanged
    a_req_held: assert property (
        @(posedge clk) disable iff (reset)
        bus_req && !grant |=> bus_req && $stable(bus_req_type) && $stable(bus_node_id)
    );

    // forwarder only ends a stream the controller waits for
    a_stream_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        stream_done |-> forward_en
    );

endmodule

`default_nettype wire

/* logic/edge_pe_pkg.sv */
`default_nettype none

`include "edge_pe_config.svh"

package edge_pe_pkg;

    typedef logic [`NODE_ID_WIDTH-1:0] node_id_t;

    // count or index that must hold MAX_NEIGHBORS itself
    typedef logic [$clog2(`MAX_NEIGHBORS + 1)-1:0] neighbor_cnt_t;

    typedef logic [`FV_WIDTH-1:0] fv_t;

    // lane i = beat bits 16i+15:16i
    typedef fv_t [`FV_LANES-1:0] fv_lanes_t;

    typedef logic [`FV_BEAT_WIDTH-1:0] fv_beat_t;

    typedef logic [`ID_BEAT_WIDTH-1:0] id_beat_t;

    // arbiter request kind
    typedef enum logic {
        REQ_NEIGHBOR_ID = 1'b0,
        REQ_NEIGHBOR_FV = 1'b1
    } req_type_t;

endpackage

`default_nettype wire

/* logic/edge_pe_top.sv */
`default_nettype none

module edge_pe_top (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             task_valid,
    input  wire edge_pe_pkg::node_id_t      task_node,
    input  wire                             grant,
    input  wire                             id_sos,
    input  wire                             id_eos,
    input  wire edge_pe_pkg::neighbor_cnt_t id_count,
    input  wire edge_pe_pkg::id_beat_t      id_beat,
    input  wire                             fv_sos,
    input  wire                             fv_eos,
    input  wire edge_pe_pkg::fv_beat_t      fv_beat,
    output logic                            idle,
    output logic                            bus_req,
    output edge_pe_pkg::req_type_t          bus_req_type,
    output edge_pe_pkg::node_id_t           bus_node_id,
    output logic                            bank_sos,
    output logic                            bank_eos,
    output edge_pe_pkg::fv_lanes_t          bank_lanes,
    output edge_pe_pkg::node_id_t           bank_node_id,
    output logic                            done_aggr
);

    logic                       capture_en;
    logic                       list_ready;
    edge_pe_pkg::neighbor_cnt_t neighbor_count;
    edge_pe_pkg::neighbor_cnt_t read_index;
    edge_pe_pkg::node_id_t      read_node;
    logic                       forward_en;
    edge_pe_pkg::node_id_t      target_node;
    logic                       stream_done;

    // list capture
    neighbor_id_buffer i_buf (
        .clk            (clk),
        .reset          (reset),
        .capture_en     (capture_en),
        .id_sos         (id_sos),
        .id_eos         (id_eos),
        .id_count       (id_count),
        .id_beat        (id_beat),
        .read_index     (read_index),
        .list_ready     (list_ready),
        .neighbor_count (neighbor_count),
        .read_node      (read_node)
    );

    edge_pe_ctrl i_ctrl (
        .clk            (clk),
        .reset          (reset),
        .task_valid     (task_valid),
        .task_node      (task_node),
        .grant          (grant),
        .list_ready     (list_ready),
        .neighbor_count (neighbor_count),
        .read_node      (read_node),
        .stream_done    (stream_done),
        .idle           (idle),
        .bus_req        (bus_req),
        .bus_req_type   (bus_req_type),
        .bus_node_id    (bus_node_id),
        .capture_en     (capture_en),
        .forward_en     (forward_en),
        .read_index     (read_index),
        .target_node    (target_node),
        .done_aggr      (done_aggr)
    );

    // feature beats to the aggregation bank
    fv_lane_forwarder i_fwd (
        .clk          (clk),
        .reset        (reset),
        .forward_en   (forward_en),
        .target_node  (target_node),
        .fv_sos       (fv_sos),
        .fv_eos       (fv_eos),
        .fv_beat      (fv_beat),
        .bank_sos     (bank_sos),
        .bank_eos     (bank_eos),
        .bank_lanes   (bank_lanes),
        .bank_node_id (bank_node_id),
        .stream_done  (stream_done)
    );

endmodule

`default_nettype wire

/* logic/fv_lane_forwarder.sv */
`default_nettype none

module fv_lane_forwarder (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        forward_en,
    input  wire edge_pe_pkg::node_id_t target_node,
    input  wire                        fv_sos,
    input  wire                        fv_eos,
    input  wire edge_pe_pkg::fv_beat_t fv_beat,
    output logic                       bank_sos,
    output logic                       bank_eos,
    output edge_pe_pkg::fv_lanes_t     bank_lanes,
    output edge_pe_pkg::node_id_t      bank_node_id,
    output logic                       stream_done
);
    import edge_pe_pkg::*;

    logic in_stream;
    logic beat_ok;

    assign beat_ok = forward_en && (fv_sos || in_stream);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_stream <= 1'b0;
            bank_sos  <= 1'b0;
            bank_eos  <= 1'b0;
        end else begin
            bank_sos <= beat_ok && fv_sos;
            bank_eos <= beat_ok && fv_eos;
            if (beat_ok)
                in_stream <= !fv_eos;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok) begin
            bank_lanes   <= fv_lanes_t'(fv_beat);
            bank_node_id <= target_node;  // tag with the node being aggregated
        end
    end

    assign stream_done = bank_eos;  // same cycle the bank sees eos

    // no second sos inside an open stream
    a_no_nested_sos: assert property (
        @(posedge clk) disable iff (reset)
        in_stream |-> !fv_sos
    );

endmodule

`default_nettype wire

/* logic/neighbor_id_buffer.sv */
`default_nettype none

`include "edge_pe_config.svh"

module neighbor_id_buffer (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             capture_en,
    input  wire                             id_sos,
    input  wire                             id_eos,
    input  wire edge_pe_pkg::neighbor_cnt_t id_count,
    input  wire edge_pe_pkg::id_beat_t      id_beat,
    input  wire edge_pe_pkg::neighbor_cnt_t read_index,
    output logic                            list_ready,
    output edge_pe_pkg::neighbor_cnt_t      neighbor_count,
    output edge_pe_pkg::node_id_t           read_node
);
    import edge_pe_pkg::*;

    node_id_t      list_mem [`MAX_NEIGHBORS];
    neighbor_cnt_t wr_ptr;
    neighbor_cnt_t base;
    logic          in_stream;
    logic          beat_ok;

    assign beat_ok = capture_en && (id_sos || in_stream);
    assign base    = id_sos ? '0 : wr_ptr;  // sos restarts the list

    always_ff @(posedge clk) begin
        if (reset) begin
            in_stream  <= 1'b0;
            wr_ptr     <= '0;
            list_ready <= 1'b0;
        end else begin
            list_ready <= beat_ok && id_eos;
            if (beat_ok) begin
                in_stream <= !id_eos;
                wr_ptr    <= id_eos ? '0 : base + neighbor_cnt_t'(`IDS_PER_BEAT);
            end
        end
    end

    // nine ids per beat
    always_ff @(posedge clk) begin
        if (beat_ok) begin
            for (int k = 0; k < `IDS_PER_BEAT; k++) begin
                if (int'(base) + k < `MAX_NEIGHBORS)
                    list_mem[int'(base) + k] <= id_beat[k*`NODE_ID_WIDTH +: `NODE_ID_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok && id_eos)
            neighbor_count <= id_count;  // count rides on the eos beat
    end

    assign read_node = list_mem[read_index];

    // write pointer stays inside the list
    a_ptr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        beat_ok |-> base < neighbor_cnt_t'(`MAX_NEIGHBORS)
    );

    a_count_valid: assert property (
        @(posedge clk) disable iff (reset)
        list_ready |-> (neighbor_count != '0) &&
                       (neighbor_count <= neighbor_cnt_t'(`MAX_NEIGHBORS))
    );

endmodule

`default_nettype wire

/* verif/edge_pe_tb.sv */
`default_nettype none

`include "edge_pe_config.svh"

module edge_pe_tb;
    import edge_pe_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int REQ_WAIT     = 20;  // cycles allowed before a request shows
    localparam int DONE_WAIT    = 20;
    localparam int MAX_DELAY    = 5;   // grant latency range 0..MAX_DELAY

    logic          clk = 1'b0;
    logic          reset;
    logic          task_valid;
    node_id_t      task_node;
    logic          grant;
    logic          id_sos;
    logic          id_eos;
    neighbor_cnt_t id_count;
    id_beat_t      id_beat;
    logic          fv_sos;
    logic          fv_eos;
    fv_beat_t      fv_beat;
    logic          idle;
    logic          bus_req;
    req_type_t     bus_req_type;
    node_id_t      bus_node_id;
    logic          bank_sos;
    logic          bank_eos;
    fv_lanes_t     bank_lanes;
    node_id_t      bank_node_id;
    logic          done_aggr;

    integer   seed = 37197;
    int       errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       test_errors_at_start;
    string    test_name;
    int       neg_cycle = 0;
    node_id_t nbr_ids[$];

    // expected bank beats tagged with the negedge count they appear at
    int        exp_at[$];
    logic      exp_sos[$];
    logic      exp_eos[$];
    fv_lanes_t exp_lanes[$];
    node_id_t  exp_node[$];

    edge_pe_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .task_valid   (task_valid),
        .task_node    (task_node),
        .grant        (grant),
        .id_sos       (id_sos),
        .id_eos       (id_eos),
        .id_count     (id_count),
        .id_beat      (id_beat),
        .fv_sos       (fv_sos),
        .fv_eos       (fv_eos),
        .fv_beat      (fv_beat),
        .idle         (idle),
        .bus_req      (bus_req),
        .bus_req_type (bus_req_type),
        .bus_node_id  (bus_node_id),
        .bank_sos     (bank_sos),
        .bank_eos     (bank_eos),
        .bank_lanes   (bank_lanes),
        .bank_node_id (bank_node_id),
        .done_aggr    (done_aggr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic flag_error(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_node(input node_id_t act, input node_id_t exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_lanes(input fv_lanes_t act, input fv_lanes_t exp, input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_req_type(input req_type_t act, input req_type_t exp,
                                  input string name);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // lane i holds beat bits 16i+15:16i
    function automatic fv_lanes_t lanes_of(input fv_beat_t beat);
        fv_lanes_t lanes;
        for (int i = 0; i < `FV_LANES; i++)
            lanes[i] = beat[i*`FV_WIDTH +: `FV_WIDTH];
        return lanes;
    endfunction

    function automatic id_beat_t pack_ids(input int first);
        id_beat_t beat;
        beat = '0;
        for (int k = 0; k < `IDS_PER_BEAT; k++) begin
            if (first + k < nbr_ids.size())
                beat[k*`NODE_ID_WIDTH +: `NODE_ID_WIDTH] = nbr_ids[first + k];
        end
        return beat;
    endfunction

    function automatic int worst_cycles(input int n_nbr, input int fv_beats);
        int list_beats;
        list_beats = (n_nbr + `IDS_PER_BEAT - 1) / `IDS_PER_BEAT;
        return (n_nbr + 1) * (REQ_WAIT + MAX_DELAY + 4) + list_beats + 1
               + n_nbr * (fv_beats + 1) + DONE_WAIT + 4;
    endfunction

    // nothing may leave the bank port unless expected
    always @(negedge clk) begin
        neg_cycle = neg_cycle + 1;
        if (!reset) begin
            if (exp_at.size() > 0 && exp_at[0] == neg_cycle) begin
                check_bit(bank_sos, exp_sos.pop_front(), "bank_sos");
                check_bit(bank_eos, exp_eos.pop_front(), "bank_eos");
                check_lanes(bank_lanes, exp_lanes.pop_front(), "bank_lanes");
                check_node(bank_node_id, exp_node.pop_front(), "bank_node_id");
                void'(exp_at.pop_front());
            end else begin
                check_bit(bank_sos, 1'b0, "bank_sos");
                check_bit(bank_eos, 1'b0, "bank_eos");
            end
        end
    end

    task automatic wait_req(input req_type_t typ, input node_id_t node, output int waited);
        waited = 0;
        @(negedge clk);
        while (!bus_req && waited < REQ_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!bus_req) begin
            flag_error($sformatf("no bus request within %0d cycles", REQ_WAIT));
        end else begin
            check_req_type(bus_req_type, typ, "bus_req_type");
            check_node(bus_node_id, node, "bus_node_id");
        end
    endtask

    // late grant must leave the request standing
    task automatic grant_req(input int delay);
        repeat (delay) begin
            @(posedge clk);
            @(negedge clk);
            check_bit(bus_req, 1'b1, "bus_req");
        end
        @(posedge clk);
        grant <= 1'b1;
        @(posedge clk);
        grant <= 1'b0;
        @(negedge clk);
        check_bit(bus_req, 1'b0, "bus_req");
    endtask

    task automatic send_list(input int n_nbr, input int list_beats);
        for (int b = 0; b < list_beats; b++) begin
            @(posedge clk);
            id_sos   <= (b == 0);
            id_eos   <= (b == list_beats - 1);
            id_count <= neighbor_cnt_t'(n_nbr);
            id_beat  <= pack_ids(b * `IDS_PER_BEAT);
        end
        @(posedge clk);
        id_sos <= 1'b0;
        id_eos <= 1'b0;
    endtask

    task automatic send_fv(input int n_beats, input node_id_t node);
        fv_beat_t beat;
        for (int b = 0; b < n_beats; b++) begin
            @(posedge clk);
            beat = {$random(seed), $random(seed)};
            fv_sos  <= (b == 0);
            fv_eos  <= (b == n_beats - 1);
            fv_beat <= beat;
            exp_at.push_back(neg_cycle + 2);  // sampled next edge and shown one later
            exp_sos.push_back(b == 0);
            exp_eos.push_back(b == n_beats - 1);
            exp_lanes.push_back(lanes_of(beat));
            exp_node.push_back(node);
        end
        @(posedge clk);
        fv_sos <= 1'b0;
        fv_eos <= 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done_aggr && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done_aggr) begin
            flag_error("done_aggr never pulsed after the last feature stream");
        end else begin
            @(negedge clk);
            check_bit(done_aggr, 1'b0, "done_aggr");
            check_bit(idle, 1'b1, "idle");
        end
        if (exp_at.size() != 0)
            flag_error($sformatf("%0d feature beats never reached the bank", exp_at.size()));
    endtask

    task automatic run_task(input node_id_t node, input int n_nbr, input int fv_beats,
                            input bit rand_each);
        int list_beats;
        int delay;
        int waited;
        nbr_ids.delete();
        for (int i = 0; i < n_nbr; i++)
            nbr_ids.push_back(node_id_t'($random(seed)));
        list_beats = (n_nbr + `IDS_PER_BEAT - 1) / `IDS_PER_BEAT;
        delay = {$random(seed)} % (MAX_DELAY + 1);
        @(posedge clk);
        task_valid <= 1'b1;
        task_node  <= node;
        @(posedge clk);
        task_valid <= 1'b0;
        wait_req(REQ_NEIGHBOR_ID, node, waited);
        if (waited != 0)
            flag_error("list request did not rise one cycle after the task");
        grant_req(delay);
        send_list(n_nbr, list_beats);
        for (int j = 0; j < n_nbr; j++) begin
            if (rand_each)
                delay = {$random(seed)} % (MAX_DELAY + 1);
            wait_req(REQ_NEIGHBOR_FV, nbr_ids[j], waited);
            grant_req(delay);
            send_fv(fv_beats, node);
        end
        wait_done();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == test_errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", test_name, errors - test_errors_at_start);
        end
    endtask

    task automatic test_reset_values();
        start_test("reset values");
        @(negedge clk);
        check_bit(idle, 1'b1, "idle");
        check_bit(bus_req, 1'b0, "bus_req");
        check_bit(bank_sos, 1'b0, "bank_sos");
        check_bit(bank_eos, 1'b0, "bank_eos");
        check_bit(done_aggr, 1'b0, "done_aggr");
        finish_test();
    endtask

    task automatic test_one_beat_list();
        start_test("one-beat list");
        run_task(7'h15, 3, 1, 1'b0);
        finish_test();
    endtask

    task automatic test_two_beat_list();
        start_test("two-beat list, random grants");
        run_task(7'h2a, 12, 1, 1'b1);
        finish_test();
    endtask

    task automatic test_long_streams();
        start_test("three-beat feature streams");
        run_task(7'h33, 4, 3, 1'b0);
        finish_test();
    endtask

    task automatic test_stray_beats();
        start_test("stray beats while idle");
        @(posedge clk);
        fv_sos  <= 1'b1;
        fv_beat <= {$random(seed), $random(seed)};
        @(posedge clk);
        fv_sos   <= 1'b0;
        fv_eos   <= 1'b1;
        fv_beat  <= {$random(seed), $random(seed)};
        id_sos   <= 1'b1;
        id_eos   <= 1'b1;
        id_count <= neighbor_cnt_t'(5);
        id_beat  <= {$random(seed), $random(seed)};
        @(posedge clk);
        fv_eos <= 1'b0;
        id_sos <= 1'b0;
        id_eos <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_bit(idle, 1'b1, "idle");
            check_bit(bus_req, 1'b0, "bus_req");
        end
        run_task(7'h41, 2, 1, 1'b0);
        finish_test();
    endtask

    // watchdog at twice the summed worst case of all tests
    initial begin
        int limit;
        limit = 2 * (RESET_CYCLES + 2 + worst_cycles(3, 1) + worst_cycles(12, 1)
                     + worst_cycles(4, 3) + 10 + worst_cycles(2, 1));
        #(limit * CLK_PERIOD);
        $display("run timed out after %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        task_valid = 1'b0;
        task_node  = '0;
        grant      = 1'b0;
        id_sos     = 1'b0;
        id_eos     = 1'b0;
        id_count   = '0;
        id_beat    = '0;
        fv_sos     = 1'b0;
        fv_eos     = 1'b0;
        fv_beat    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset_values();
        test_one_beat_list();
        test_two_beat_list();
        test_long_streams();
        test_stray_beats();

        $display("%0d tests, %0d failed, %0d checks failed", tests_run, tests_failed, errors);
        if (errors > 0)
            $display("Test failures found");
        else
            $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/edge_pe_pkg.sv
logic/neighbor_id_buffer.sv
logic/edge_pe_ctrl.sv
logic/fv_lane_forwarder.sv
logic/edge_pe_top.sv
verif/edge_pe_tb.sv
